// ==== Bender.yml ====
package:
  name: cache_subsystem

sources:
  - include_dirs:
      - common
    files:
      - common/cache_pkg.sv
      - common/mem_if.sv
      - dcache/victim_lfsr.sv
      - dcache/dca.sv
      - hdl/ica.sv
      - hdl/mem_arbiter.sv
      - hdl/cache_top.sv
      - target: simulation
        files:
          - dv/tb_clk.sv
          - dv/tb_cache.sv

// ==== common/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

`define PA_WIDTH    16  // physical address bits
`define LINE_BYTES  16
`define D_SECTORS   4   // data cache sets
`define D_WAYS      2
`define I_LINES     8

// top id bit names the owner, 0 data cache, 1 instruction cache
`define ID_WIDTH    3

`endif

// ==== common/cache_pkg.sv ====
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`PA_WIDTH-1:0]           pa_t;
    typedef logic [`LINE_BYTES*8-1:0]       line_t;
    typedef logic [31:0]                    word_t;
    typedef logic [`ID_WIDTH-1:0]           mem_id_t;
    typedef logic [$clog2(`D_WAYS)-1:0]     way_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

    typedef struct packed {
        logic       enable;
        pa_t        address;
        word_t      data;           // store only
        mem_size_e  size;
        logic       use_unsigned;   // load only
    } mem_data_t;

    // bit 0 store miss outstanding, bit 1 load miss outstanding
    typedef enum logic [1:0] {
        D_IDLE,
        D_S_REQUEST,
        D_L_REQUEST,
        D_BOTH_REQUEST
    } data_cache_state;

    typedef enum logic {
        I_IDLE,
        I_WAIT
    } icache_state;

endpackage

`default_nettype wire

// ==== common/mem_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mem_if import cache_pkg::*; ();

    logic       req;        // one-cycle strobe
    logic       write;      // line write-back, no response
    pa_t        addr;       // line aligned
    line_t      wdata;
    mem_id_t    next_id;    // id the next read will carry
    logic       rsp;
    line_t      rdata;
    mem_id_t    rsp_id;
    logic       ack;

    modport requester (
        output req, write, addr, wdata, ack,
        input  next_id, rsp, rdata, rsp_id
    );

    modport arbiter (
        input  req, write, addr, wdata, ack,
        output next_id, rsp, rdata, rsp_id
    );

endinterface

`default_nettype wire

// ==== dcache/dca.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_defines.svh"

module dca import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  mem_data_t   i_load,
    input  mem_data_t   i_store,
    input  logic        i_sb_hit,   // store buffer already covers the load
    output logic        o_hit,
    output logic        o_miss,
    output word_t       o_read_data,
    mem_if.requester    mem
);

    localparam int OFF_W = $clog2(`LINE_BYTES);
    localparam int SET_W = $clog2(`D_SECTORS);
    localparam int TAG_W = `PA_WIDTH - OFF_W - SET_W;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [SET_W-1:0]   sector;
        way_t               way;
        mem_id_t            id;
    } reg_entry_t;

    line_t                  lines      [`D_SECTORS][`D_WAYS];
    logic [TAG_W-1:0]       tags       [`D_SECTORS][`D_WAYS];
    logic [`D_WAYS-1:0]     valid_bits [`D_SECTORS];
    logic [`D_WAYS-1:0]     dirty_bits [`D_SECTORS];

    reg_entry_t             registry [2];   // 0 store miss, 1 load miss
    logic                   req_slot;

    data_cache_state        state;
    data_cache_state        next_state;

    pa_t                    cur_addr;
    logic [OFF_W-1:0]       cur_off;
    logic [SET_W-1:0]       cur_set;
    logic [TAG_W-1:0]       cur_tag;
    logic [`D_WAYS-1:0]     hit_vec;
    way_t                   hit_way;
    way_t                   victim;
    line_t                  line_rd;
    logic [3:0]             st_mask;

    logic                   s_pend;
    logic                   l_pend;
    logic                   s_line_busy;
    logic                   issue_s;
    logic                   issue_l;
    logic                   store_now;
    logic                   hit_s;
    logic                   hit_l;
    logic                   fill;
    logic                   wb_now;
    reg_entry_t             fill_ent;

    victim_lfsr lfsr0 (
        .clk        (clk),
        .rst        (rst),
        .i_advance  (issue_s || issue_l),
        .o_way      (victim)
    );

    assign cur_addr = i_load.enable ? i_load.address : i_store.address;
    assign cur_off  = cur_addr[OFF_W-1:0];
    assign cur_set  = cur_addr[OFF_W +: SET_W];
    assign cur_tag  = cur_addr[`PA_WIDTH-1 -: TAG_W];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `D_WAYS; w++) begin
            hit_vec[w] = valid_bits[cur_set][w] && (tags[cur_set][w] == cur_tag);
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign o_hit  = (i_load.enable || i_store.enable) && |hit_vec;
    assign o_miss = i_load.enable && !o_hit;

    always_comb begin
        line_rd = lines[cur_set][hit_way] >> {cur_off, 3'b000};
        case (i_load.size)
            SIZE_BYTE: o_read_data = i_load.use_unsigned ? {24'b0, line_rd[7:0]}
                                                         : {{24{line_rd[7]}}, line_rd[7:0]};
            SIZE_HALF: o_read_data = i_load.use_unsigned ? {16'b0, line_rd[15:0]}
                                                         : {{16{line_rd[15]}}, line_rd[15:0]};
            default:   o_read_data = line_rd[31:0];
        endcase
    end

    always_comb begin
        case (i_store.size)
            SIZE_BYTE: st_mask = 4'b0001;
            SIZE_HALF: st_mask = 4'b0011;
            default:   st_mask = 4'b1111;
        endcase
    end

    assign s_pend = (state == D_S_REQUEST) || (state == D_BOTH_REQUEST);
    assign l_pend = (state == D_L_REQUEST) || (state == D_BOTH_REQUEST);

    assign hit_s    = mem.rsp && s_pend && (mem.rsp_id == registry[0].id);
    assign hit_l    = mem.rsp && l_pend && (mem.rsp_id == registry[1].id);
    assign fill     = hit_s || hit_l;
    assign fill_ent = registry[hit_l];
    assign wb_now   = fill && dirty_bits[fill_ent.sector][fill_ent.way];

    // a load to the line the store is already fetching just waits for it
    assign s_line_busy = s_pend && (registry[0].tag == cur_tag)
                       && (registry[0].sector == cur_set);

    // the write-back owns the bus slot, a blocked miss retries next cycle
    assign issue_s   = i_store.enable && !i_load.enable && !o_hit && !s_pend && !wb_now;
    assign issue_l   = i_load.enable && !o_hit && !i_sb_hit && !l_pend && !s_line_busy
                     && !wb_now;
    assign store_now = i_store.enable && !i_load.enable && o_hit;

    assign next_state = data_cache_state'({issue_l || (l_pend && !hit_l),
                                           issue_s || (s_pend && !hit_s)});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= D_IDLE;
            mem.req <= 1'b0;
            mem.ack <= 1'b0;
            for (int s = 0; s < `D_SECTORS; s++) begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
            end
        end else begin
            state   <= next_state;
            mem.req <= issue_s || issue_l || wb_now;
            mem.ack <= fill;
            if (fill) begin
                valid_bits[fill_ent.sector][fill_ent.way] <= 1'b1;
                dirty_bits[fill_ent.sector][fill_ent.way] <= 1'b0;
            end
            if (store_now) begin
                dirty_bits[cur_set][hit_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            lines[fill_ent.sector][fill_ent.way] <= mem.rdata;
            tags[fill_ent.sector][fill_ent.way]  <= fill_ent.tag;
        end
        if (store_now) begin
            for (int b = 0; b < 4; b++) begin
                if (st_mask[b]) begin
                    lines[cur_set][hit_way][8*((cur_off + b) % `LINE_BYTES) +: 8]
                        <= i_store.data[8*b +: 8];
                end
            end
        end
        if (wb_now) begin
            mem.write <= 1'b1;  // old victim contents, fill lands at the same edge
            mem.addr  <= {tags[fill_ent.sector][fill_ent.way], fill_ent.sector, {OFF_W{1'b0}}};
            mem.wdata <= lines[fill_ent.sector][fill_ent.way];
        end else if (issue_s || issue_l) begin
            mem.write         <= 1'b0;
            mem.addr          <= {cur_tag, cur_set, {OFF_W{1'b0}}};
            registry[issue_l] <= '{tag: cur_tag, sector: cur_set, way: victim, id: '1};
            req_slot          <= issue_l;
        end
        // id is taken while the read is on the bus, all ones never routes here
        if (mem.req && !mem.write) begin
            registry[req_slot].id <= mem.next_id;
        end
    end

    a_rsp_owned: assert property (@(posedge clk) disable iff (rst) mem.rsp |-> fill);

    a_one_way: assert property (@(posedge clk) disable iff (rst) o_hit |-> $onehot(hit_vec));

endmodule

`default_nettype wire

// ==== dcache/victim_lfsr.sv ====
`timescale 1ns/10ps
`default_nettype none

module victim_lfsr import cache_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_advance,
    output way_t    o_way
);

    logic [2:0] lfsr;

    // x^3 + x^2 + 1, period 7
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= 3'b001;
        end else if (i_advance) begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    assign o_way = way_t'(lfsr); // low bits

endmodule

`default_nettype wire

// ==== dv/tb_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_defines.svh"

module tb_cache import cache_pkg::*; ();

    localparam int MEM_BYTES  = 1 << `PA_WIDTH;
    // load sweep, store merge, eviction, two misses, fetch mix, bypass
    localparam int N_OPS      = 2*88 + 9*5 + 12 + 12 + 32 + 1;
    localparam int MAX_CYCLES = N_OPS * 30;

    logic       clk;
    logic       rst;
    logic       i_load_enable;
    pa_t        i_load_addr;
    mem_size_e  i_load_size;
    logic       i_load_unsigned;
    logic       i_store_enable;
    pa_t        i_store_addr;
    word_t      i_store_data;
    mem_size_e  i_store_size;
    logic       i_sb_hit;
    logic       o_d_hit;
    logic       o_d_miss;
    word_t      o_read_data;
    logic       i_fetch_enable;
    pa_t        i_fetch_addr;
    logic       o_fetch_hit;
    word_t      o_fetch_instr;
    logic       o_mem_enable;
    logic       o_mem_write;
    pa_t        o_mem_addr;
    line_t      o_mem_data;
    mem_id_t    o_mem_id;
    logic       i_mem_valid;
    line_t      i_mem_data;
    mem_id_t    i_mem_id;

    logic [7:0] mem     [MEM_BYTES];    // external memory
    logic [7:0] ref_mem [MEM_BYTES];    // what the core should read
    mem_id_t    q_id   [$];             // reads in flight
    pa_t        q_addr [$];
    int         q_wait [$];
    logic       watch_on;
    pa_t        watch_addr;
    int         cycles;
    pa_t        fetch_addrs [16];
    pa_t        load_addrs  [16];
    pa_t        line_base   [2];

    tb_clk clk0 (.clk(clk), .rst(rst));

    cache_top dut0 (.*);

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_hit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Error %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    function automatic int nbytes(mem_size_e sz);
        case (sz)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic line_t line_at(pa_t a);
        line_t l;
        int base;
        base = int'(a) & ~(`LINE_BYTES - 1);
        for (int i = 0; i < `LINE_BYTES; i++) begin
            l[8*i +: 8] = mem[base + i];    // byte 0 in the low bits
        end
        return l;
    endfunction

    function automatic word_t ref_load(pa_t a, mem_size_e sz, logic uns);
        word_t v;
        int n;
        n = nbytes(sz);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[int'(a) + i];
        end
        if (!uns && v[8*n-1]) begin
            v = v | (32'hffff_ffff << (8*n));   // sign fill
        end
        return v;
    endfunction

    function automatic word_t ref_fetch(pa_t a);
        word_t v;
        for (int i = 0; i < 4; i++) begin
            v[8*i +: 8] = ref_mem[(int'(a) & ~3) + i];
        end
        return v;
    endfunction

    // called on a falling edge, held until the hit edge
    task automatic run_load(pa_t a, mem_size_e sz, logic uns, string name);
        i_load_enable   = 1'b1;
        i_load_addr     = a;
        i_load_size     = sz;
        i_load_unsigned = uns;
        do begin
            @(posedge clk);
            if (!o_d_hit) begin
                check_hit({name, " miss flag"}, 1'b1, o_d_miss);
            end
        end while (!o_d_hit);
        check_word(name, ref_load(a, sz, uns), o_read_data);
        @(negedge clk);
        i_load_enable = 1'b0;
    endtask

    task automatic start_store(pa_t a, mem_size_e sz, word_t d);
        i_store_enable = 1'b1;
        i_store_addr   = a;
        i_store_size   = sz;
        i_store_data   = d;
    endtask

    task automatic finish_store();
        do begin
            @(posedge clk);
        end while (!(o_d_hit && !i_load_enable));
        for (int i = 0; i < nbytes(i_store_size); i++) begin
            ref_mem[int'(i_store_addr) + i] = i_store_data[8*i +: 8];
        end
        @(negedge clk);
        i_store_enable = 1'b0;
    endtask

    task automatic run_fetch(pa_t a);
        i_fetch_enable = 1'b1;
        i_fetch_addr   = a;
        do begin
            @(posedge clk);
        end while (!o_fetch_hit);
        check_word($sformatf("fetch %h", a), ref_fetch(a), o_fetch_instr);
        @(negedge clk);
        i_fetch_enable = 1'b0;
    endtask

    // one response per cycle, random pick among the ready reads
    always @(negedge clk) begin
        int start;
        int pick;
        pick        = -1;
        i_mem_valid = 1'b0;
        for (int j = 0; j < q_wait.size(); j++) begin
            q_wait[j] = q_wait[j] - 1;
        end
        if (q_wait.size() > 0) begin
            start = $urandom_range(q_wait.size() - 1);
            for (int j = 0; j < q_wait.size(); j++) begin
                if (pick < 0 && q_wait[(start + j) % q_wait.size()] <= 0) begin
                    pick = (start + j) % q_wait.size();
                end
            end
        end
        if (pick >= 0) begin
            i_mem_valid = 1'b1;
            i_mem_id    = q_id[pick];
            i_mem_data  = line_at(q_addr[pick]);
            q_id.delete(pick);
            q_addr.delete(pick);
            q_wait.delete(pick);
        end
        if (!rst && o_mem_enable === 1'b1) begin
            if (o_mem_write) begin
                for (int i = 0; i < `LINE_BYTES; i++) begin
                    mem[int'(o_mem_addr) + i] = o_mem_data[8*i +: 8];
                end
            end else begin
                if (watch_on && o_mem_addr == watch_addr) begin
                    $display("read request for line %h went out while the store buffer covered it",
                             o_mem_addr);
                    abort_run();
                end
                q_id.push_back(o_mem_id);
                q_addr.push_back(o_mem_addr);
                q_wait.push_back($urandom_range(12, 2));
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles with a request still held", cycles);
            abort_run();
        end
    end

    initial begin
        void'($urandom(32'h33ee));
        cycles          = 0;
        watch_on        = 1'b0;
        watch_addr      = '0;
        i_load_enable   = 1'b0;
        i_load_addr     = '0;
        i_load_size     = SIZE_BYTE;
        i_load_unsigned = 1'b0;
        i_store_enable  = 1'b0;
        i_store_addr    = '0;
        i_store_data    = '0;
        i_store_size    = SIZE_BYTE;
        i_sb_hit        = 1'b0;
        i_fetch_enable  = 1'b0;
        i_fetch_addr    = '0;
        i_mem_valid     = 1'b0;
        i_mem_data      = '0;
        i_mem_id        = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i]     = 8'($urandom);
            ref_mem[i] = mem[i];
        end
        wait (!rst);
        @(negedge clk);
        check_hit("reset mem enable", 1'b0, o_mem_enable);

        // every size and offset, signed and unsigned
        line_base[0] = 16'h1000;
        line_base[1] = 16'h1230;
        for (int l = 0; l < 2; l++) begin
            for (int s = 0; s < 3; s++) begin
                for (int off = 0; off <= `LINE_BYTES - nbytes(mem_size_e'(s)); off++) begin
                    for (int u = 0; u < 2; u++) begin
                        run_load(pa_t'(line_base[l] + off), mem_size_e'(s), 1'(u),
                                 $sformatf("t1 load %h size %0d", line_base[l] + off, s));
                    end
                end
            end
        end

        // merge of each store size into the line
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k < 3; k++) begin
                start_store(pa_t'(16'h3450 + 5*k), mem_size_e'(s), $urandom);
                finish_store();
                for (int w = 0; w < `LINE_BYTES; w += 4) begin
                    run_load(pa_t'(16'h3450 + w), SIZE_WORD, 1'b0,
                             $sformatf("t2 merge size %0d word %0d", s, w));
                end
            end
        end

        // six lines into set 2, dirty victims go back to memory
        for (int k = 0; k < 6; k++) begin
            start_store(pa_t'(16'h4024 + 16'h40*k), SIZE_WORD, $urandom);
            finish_store();
        end
        for (int k = 0; k < 6; k++) begin
            run_load(pa_t'(16'h4024 + 16'h40*k), SIZE_WORD, 1'b0, $sformatf("t3 reload %0d", k));
        end

        // store miss in set 0 still open when the load misses in set 1
        for (int k = 0; k < 4; k++) begin
            start_store(pa_t'(16'h6008 + 16'h100*k), SIZE_WORD, $urandom);
            @(negedge clk);
            run_load(pa_t'(16'h6814 + 16'h100*k), SIZE_WORD, 1'b0, $sformatf("t4 load %0d", k));
            finish_store();
            run_load(pa_t'(16'h6008 + 16'h100*k), SIZE_WORD, 1'b0, $sformatf("t4 store %0d", k));
        end

        for (int k = 0; k < 16; k++) begin
            fetch_addrs[k] = pa_t'(16'h8000 + 4*$urandom_range(63));
            load_addrs[k]  = pa_t'(16'h5000 + 4*$urandom_range(63));
        end
        fork
            for (int k = 0; k < 16; k++) begin
                run_fetch(fetch_addrs[k]);
            end
            for (int k = 0; k < 16; k++) begin
                run_load(load_addrs[k], SIZE_WORD, 1'b0, $sformatf("t5 load %h", load_addrs[k]));
            end
        join

        // bypassed load must not fetch its line
        watch_addr      = 16'h7000;
        watch_on        = 1'b1;
        i_sb_hit        = 1'b1;
        i_load_enable   = 1'b1;
        i_load_addr     = 16'h7004;
        i_load_size     = SIZE_WORD;
        i_load_unsigned = 1'b0;
        repeat (20) begin
            @(posedge clk);
            check_hit("t6 held miss", 1'b1, o_d_miss);
        end
        @(negedge clk);
        i_load_enable = 1'b0;
        i_sb_hit      = 1'b0;
        repeat (2) @(negedge clk);
        watch_on = 1'b0;

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clk.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk (
    output logic clk,
    output logic rst
);

    localparam int HALF = 5;    // 10 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #HALF clk = ~clk;
        end
    end

    // two rising edges in reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hdl/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // data side
    input  logic        i_load_enable,
    input  pa_t         i_load_addr,
    input  mem_size_e   i_load_size,
    input  logic        i_load_unsigned,
    input  logic        i_store_enable,
    input  pa_t         i_store_addr,
    input  word_t       i_store_data,
    input  mem_size_e   i_store_size,
    input  logic        i_sb_hit,
    output logic        o_d_hit,
    output logic        o_d_miss,
    output word_t       o_read_data,
    // fetch side
    input  logic        i_fetch_enable,
    input  pa_t         i_fetch_addr,
    output logic        o_fetch_hit,
    output word_t       o_fetch_instr,
    // external memory
    output logic        o_mem_enable,
    output logic        o_mem_write,
    output pa_t         o_mem_addr,
    output line_t       o_mem_data,
    output mem_id_t     o_mem_id,
    input  logic        i_mem_valid,
    input  line_t       i_mem_data,
    input  mem_id_t     i_mem_id
);

    mem_data_t  load_req;
    mem_data_t  store_req;

    mem_if d_bus ();
    mem_if i_bus ();

    assign load_req  = '{enable: i_load_enable, address: i_load_addr, data: word_t'(0),
                         size: i_load_size, use_unsigned: i_load_unsigned};
    assign store_req = '{enable: i_store_enable, address: i_store_addr, data: i_store_data,
                         size: i_store_size, use_unsigned: 1'b0};

    dca dca0 (
        .clk(clk), .rst(rst),
        .i_load(load_req), .i_store(store_req), .i_sb_hit(i_sb_hit),
        .o_hit(o_d_hit), .o_miss(o_d_miss), .o_read_data(o_read_data),
        .mem(d_bus.requester)
    );

    ica ica0 (
        .clk(clk), .rst(rst),
        .i_fetch_enable(i_fetch_enable), .i_fetch_addr(i_fetch_addr),
        .o_fetch_hit(o_fetch_hit), .o_fetch_instr(o_fetch_instr),
        .mem(i_bus.requester)
    );

    mem_arbiter arb0 (
        .clk(clk), .rst(rst),
        .i_mem_valid(i_mem_valid), .i_mem_data(i_mem_data), .i_mem_id(i_mem_id),
        .d_mem(d_bus.arbiter), .i_mem(i_bus.arbiter),
        .o_mem_enable(o_mem_enable), .o_mem_write(o_mem_write), .o_mem_addr(o_mem_addr),
        .o_mem_data(o_mem_data), .o_mem_id(o_mem_id)
    );

endmodule

`default_nettype wire

// ==== hdl/ica.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_defines.svh"

module ica import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_fetch_enable,
    input  pa_t         i_fetch_addr,
    output logic        o_fetch_hit,
    output word_t       o_fetch_instr,
    mem_if.requester    mem
);

    localparam int OFF_W = $clog2(`LINE_BYTES);
    localparam int IDX_W = $clog2(`I_LINES);
    localparam int TAG_W = `PA_WIDTH - OFF_W - IDX_W;

    line_t                  lines [`I_LINES];
    logic [TAG_W-1:0]       tags  [`I_LINES];
    logic [`I_LINES-1:0]    valid_bits;

    icache_state            state;
    mem_id_t                pend_id;
    logic [TAG_W-1:0]       pend_tag;
    logic [IDX_W-1:0]       pend_idx;

    logic [IDX_W-1:0]       idx;
    logic [TAG_W-1:0]       tag;
    logic                   issue;
    logic                   fill;

    assign idx = i_fetch_addr[OFF_W +: IDX_W];
    assign tag = i_fetch_addr[`PA_WIDTH-1 -: TAG_W];

    assign o_fetch_hit   = i_fetch_enable && valid_bits[idx] && (tags[idx] == tag);
    assign o_fetch_instr = word_t'(lines[idx] >> {i_fetch_addr[OFF_W-1:2], 5'b00000});

    assign issue = (state == I_IDLE) && i_fetch_enable && !o_fetch_hit;
    assign fill  = (state == I_WAIT) && mem.rsp && (mem.rsp_id == pend_id);

    assign mem.write = 1'b0;    // read only
    assign mem.wdata = '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= I_IDLE;
            mem.req    <= 1'b0;
            mem.ack    <= 1'b0;
            valid_bits <= '0;
        end else begin
            mem.req <= issue;
            mem.ack <= fill;
            if (issue) begin
                state <= I_WAIT;
            end else if (fill) begin
                state                <= I_IDLE;
                valid_bits[pend_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            mem.addr <= {tag, idx, {OFF_W{1'b0}}};
            pend_tag <= tag;
            pend_idx <= idx;
        end
        if (mem.req) begin
            pend_id <= mem.next_id;
        end
        if (fill) begin
            lines[pend_idx] <= mem.rdata;
            tags[pend_idx]  <= pend_tag;
        end
    end

    // past the first wait cycle the bus stays quiet until the refill
    a_no_req_wait: assert property (@(posedge clk) disable iff (rst)
        (state == I_WAIT) && $past(state == I_WAIT) |-> !mem.req);

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_defines.svh"

module mem_arbiter import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_mem_valid,
    input  line_t       i_mem_data,
    input  mem_id_t     i_mem_id,
    mem_if.arbiter      d_mem,
    mem_if.arbiter      i_mem,
    output logic        o_mem_enable,
    output logic        o_mem_write,
    output pa_t         o_mem_addr,
    output line_t       o_mem_data,
    output mem_id_t     o_mem_id
);

    localparam int CNT_W = `ID_WIDTH - 1;

    logic [CNT_W-1:0]   d_cnt;
    logic [CNT_W-1:0]   i_cnt;

    logic               skid_full;
    logic               skid_write;
    pa_t                skid_addr;
    line_t              skid_wdata;
    mem_id_t            skid_id;
    logic               load_skid;

    assign d_mem.next_id = {1'b0, d_cnt};
    assign i_mem.next_id = {1'b1, i_cnt};

    assign load_skid = i_mem.req && (d_mem.req || skid_full);

    // data cache first, then the parked fetch request
    always_comb begin
        if (d_mem.req) begin
            {o_mem_enable, o_mem_write} = {1'b1, d_mem.write};
            {o_mem_addr, o_mem_data, o_mem_id} = {d_mem.addr, d_mem.wdata, d_mem.next_id};
        end else if (skid_full) begin
            {o_mem_enable, o_mem_write} = {1'b1, skid_write};
            {o_mem_addr, o_mem_data, o_mem_id} = {skid_addr, skid_wdata, skid_id};
        end else begin
            {o_mem_enable, o_mem_write} = {i_mem.req, i_mem.write};
            {o_mem_addr, o_mem_data, o_mem_id} = {i_mem.addr, i_mem.wdata, i_mem.next_id};
        end
    end

    assign d_mem.rsp    = i_mem_valid && !i_mem_id[`ID_WIDTH-1];
    assign i_mem.rsp    = i_mem_valid && i_mem_id[`ID_WIDTH-1];
    assign d_mem.rdata  = i_mem_data;
    assign i_mem.rdata  = i_mem_data;
    assign d_mem.rsp_id = i_mem_id;
    assign i_mem.rsp_id = i_mem_id;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d_cnt     <= '0;
            i_cnt     <= '0;
            skid_full <= 1'b0;
        end else begin
            if (d_mem.req && !d_mem.write) begin
                d_cnt <= d_cnt + 1'b1;
            end
            if (i_mem.req && !i_mem.write) begin
                i_cnt <= i_cnt + 1'b1;
            end
            if (load_skid) begin
                skid_full <= 1'b1;
            end else if (!d_mem.req) begin
                skid_full <= 1'b0;  // drained this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_skid) begin
            skid_write <= i_mem.write;
            skid_addr  <= i_mem.addr;
            skid_wdata <= i_mem.wdata;
            skid_id    <= i_mem.next_id;
        end
    end

    a_skid_single: assert property (@(posedge clk) disable iff (rst) load_skid |-> !skid_full);

    // each peer acks only a response that was routed to it
    a_ack_owner: assert property (@(posedge clk) disable iff (rst)
        (d_mem.ack |-> $past(d_mem.rsp)) and (i_mem.ack |-> $past(i_mem.rsp)));

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/cache_pkg.sv
common/mem_if.sv
dcache/victim_lfsr.sv
dcache/dca.sv
hdl/ica.sv
hdl/mem_arbiter.sv
hdl/cache_top.sv
dv/tb_clk.sv
dv/tb_cache.sv
